// ==== common/idct_pkg.sv ====
`default_nettype none

package idct_pkg;

	// widths
	localparam int SAMPLE_W = 16;
	localparam int WORD_W = 32;
	localparam int SRAM_ADDR_W = 18;
	localparam int BUF_ADDR_W = 5;
	localparam int PIXEL_W = 8;

	// block geometry, luma plane of 320x240
	localparam int BLOCK_N = 8;
	localparam int BLOCKS_X = 40;
	localparam int BLOCKS_Y = 30;

	// sram layout in 16-bit words
	localparam int PRE_IDCT_BASE = 76800;
	localparam int PRE_ROW_STRIDE = 320;
	localparam int POST_IDCT_BASE = 0;
	localparam int POST_ROW_STRIDE = 160;
	localparam int SRAM_READ_LATENCY = 2;

	localparam int T_SHIFT = 8;
	localparam int S_SHIFT = 16;

	// entry [k*8+c] = round(2048 * a(k) * cos((2c+1)k*pi/16))
	localparam logic signed [SAMPLE_W-1:0] COS_TABLE [64] = '{
		16'sd724, 16'sd724, 16'sd724, 16'sd724, 16'sd724, 16'sd724, 16'sd724, 16'sd724,
		16'sd1004, 16'sd851, 16'sd569, 16'sd200, -16'sd200, -16'sd569, -16'sd851, -16'sd1004,
		16'sd946, 16'sd392, -16'sd392, -16'sd946, -16'sd946, -16'sd392, 16'sd392, 16'sd946,
		16'sd851, -16'sd200, -16'sd1004, -16'sd569, 16'sd569, 16'sd1004, 16'sd200, -16'sd851,
		16'sd724, -16'sd724, -16'sd724, 16'sd724, 16'sd724, -16'sd724, -16'sd724, 16'sd724,
		16'sd569, -16'sd1004, 16'sd200, 16'sd851, -16'sd851, -16'sd200, 16'sd1004, -16'sd569,
		16'sd392, -16'sd946, 16'sd946, -16'sd392, -16'sd392, 16'sd946, -16'sd946, 16'sd392,
		16'sd200, -16'sd569, 16'sd851, -16'sd1004, 16'sd1004, -16'sd851, 16'sd569, -16'sd200
	};

	typedef struct packed {
		logic [SRAM_ADDR_W-1:0] address;
		logic [SAMPLE_W-1:0] write_data;
		logic write_en_n;
	} sram_req_t;

	typedef struct packed {
		logic [BUF_ADDR_W-1:0] address;
		logic [WORD_W-1:0] data;
		logic wren;
	} buf_wr_t;

	typedef struct packed {
		logic [5:0] col;
		logic [4:0] row;
	} block_pos_t;

	typedef enum logic [2:0] {
		idle,
		fetch,
		pass_t,
		pass_s,
		done
	} phase_t;

endpackage

`default_nettype wire

// ==== dv/idct_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module idct_props import idct_pkg::*; (
	input logic CLOCK_50_I,
	input logic Resetn,
	input phase_t phase,
	input sram_req_t sram,
	input logic finish
);

	// only the pixel writer drives a low write enable
	write_in_pass_s: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		!sram.write_en_n |-> phase == pass_s)
		else $error("sram write while phase is %s", phase.name());

	finish_one_cycle: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		finish |=> !finish)
		else $error("finish held high for more than one cycle");

	// pixel writes stay out of the coefficient region
	write_below_pre: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		!sram.write_en_n |-> sram.address < SRAM_ADDR_W'(PRE_IDCT_BASE))
		else $error("sram write to address %0d in the coefficient region", sram.address);

endmodule

`default_nettype wire

// ==== dv/idct_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module idct_tb import idct_pkg::*; ();

	localparam int NUM_RUNS = 41;
	localparam int NUM_ENTRIES = 6;
	localparam int BLOCK_CYCLES = 600;
	localparam int WORDS_PER_BLOCK = 32;

	typedef enum logic [1:0] {fill_zero, fill_dc, fill_random} fill_t;

	typedef struct packed {
		fill_t mode;
		logic signed [SAMPLE_W-1:0] dc;
		logic flat;
		logic signed [9:0] pixel;
	} stim_t;

	// pixel of -1 means no fixed value is expected
	// dc 4096 gives T row 0 of 4096*724/256 = 11584 and pixels of 724*11584/65536 = 127
	stim_t stim_table [NUM_ENTRIES] = '{
		'{fill_zero, 16'sd0, 1'b1, 10'sd0},
		'{fill_dc, 16'sd4096, 1'b1, 10'sd127},
		'{fill_dc, 16'sd11000, 1'b1, 10'sd255},
		'{fill_dc, -16'sd4096, 1'b1, 10'sd0},
		'{fill_random, 16'sd4000, 1'b0, -10'sd1},
		'{fill_random, 16'sd2000, 1'b0, -10'sd1}
	};

	logic CLOCK_50_I;
	logic Resetn;
	logic start;
	logic [SAMPLE_W-1:0] sram_read_data;
	sram_req_t sram;
	logic finish;

	logic [SAMPLE_W-1:0] sram_mem [2**SRAM_ADDR_W];
	logic [SAMPLE_W-1:0] read_pipe [SRAM_READ_LATENCY] = '{default: '0};
	logic [SRAM_ADDR_W-1:0] log_address [$];
	logic [SAMPLE_W-1:0] log_data [$];

	int seed = 32'h3a41_d7e9;
	int blk_row;
	int blk_col;
	int coeff [64];
	int model_pix [64];

	tb_clock i_clock (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn)
	);

	idct_top i_dut (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.start(start),
		.sram_read_data(sram_read_data),
		.sram(sram),
		.finish(finish)
	);

	bind idct_control idct_props i_props (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.phase(phase),
		.sram(sram),
		.finish(finish)
	);

	// SRAM model with a fixed read latency that logs every write
	assign sram_read_data = read_pipe[SRAM_READ_LATENCY-1];

	always @(posedge CLOCK_50_I) begin
		read_pipe[0] <= sram_mem[sram.address];
		for (int i = 1; i < SRAM_READ_LATENCY; i++) begin
			read_pipe[i] <= read_pipe[i-1];
		end
		if (Resetn && !sram.write_en_n) begin
			log_address.push_back(sram.address);
			log_data.push_back(sram.write_data);
		end
	end

	// coefficient (r, k) sits at block base + r*320 + k
	task automatic load_block(input stim_t s);
		int base;
		base = PRE_IDCT_BASE + blk_row * BLOCK_N * PRE_ROW_STRIDE + blk_col * BLOCK_N;
		for (int i = 0; i < 64; i++) begin
			case (s.mode)
				fill_random: coeff[i] = (i == 0) ? int'($signed(s.dc)) : $random(seed) % 512;
				fill_dc: coeff[i] = (i == 0) ? int'($signed(s.dc)) : 0;
				default: coeff[i] = 0;
			endcase
			sram_mem[SRAM_ADDR_W'(base + (i / 8) * PRE_ROW_STRIDE + i % 8)] = SAMPLE_W'(coeff[i]);
		end
	endtask

	// T = S'.C kept at 16 bits and S = Ct.T shifted and clipped
	task automatic model_block();
		int sum;
		logic signed [SAMPLE_W-1:0] t_mat [64];
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				sum = 0;
				for (int k = 0; k < 8; k++) begin
					sum += coeff[r*8+k] * int'(COS_TABLE[k*8+c]);
				end
				t_mat[r*8+c] = SAMPLE_W'(sum >>> T_SHIFT);
			end
		end
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				sum = 0;
				for (int k = 0; k < 8; k++) begin
					sum += int'(COS_TABLE[k*8+r]) * int'(t_mat[k*8+c]);
				end
				sum = sum >>> S_SHIFT;
				model_pix[r*8+c] = (sum < 0) ? 0 : ((sum > 255) ? 255 : sum);
			end
		end
	endtask

	task automatic check_block(input int run, input stim_t s, output int errs);
		int base;
		int idx;
		int exp_address;
		logic [SAMPLE_W-1:0] exp_word;
		logic [PIXEL_W-1:0] dut_pix [64];
		errs = 0;
		base = POST_IDCT_BASE + blk_row * BLOCK_N * POST_ROW_STRIDE + blk_col * (BLOCK_N / 2);
		assert (log_address.size() == (run + 1) * WORDS_PER_BLOCK) else begin
			$display("** Error at %0t ns: sram write count = %0d, expected %0d", $time,
				log_address.size(), (run + 1) * WORDS_PER_BLOCK);
			errs++;
		end
		for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
			idx = run * WORDS_PER_BLOCK + w;
			if (idx >= log_address.size()) begin
				$display("block %0d: write %0d never happened", run, w);
				errs++;
				dut_pix[2*w] = '0;
				dut_pix[2*w+1] = '0;
				continue;
			end
			exp_address = base + (w / 4) * POST_ROW_STRIDE + w % 4;
			exp_word = {PIXEL_W'(model_pix[2*w]), PIXEL_W'(model_pix[2*w+1])};
			assert (int'(log_address[idx]) == exp_address) else begin
				$display("** Error at %0t ns: sram.address = %0d, expected %0d", $time,
					log_address[idx], exp_address);
				errs++;
			end
			assert (log_data[idx] == exp_word) else begin
				$display("** Error at %0t ns: sram.write_data = %h, expected %h", $time,
					log_data[idx], exp_word);
				errs++;
			end
			dut_pix[2*w] = log_data[idx][SAMPLE_W-1:PIXEL_W];
			dut_pix[2*w+1] = log_data[idx][PIXEL_W-1:0];
		end
		for (int i = 0; i < 64; i++) begin
			assert (!s.flat || dut_pix[i] == dut_pix[0]) else begin
				$display("** Error at %0t ns: pixel %0d = %0d, expected flat %0d", $time, i,
					dut_pix[i], dut_pix[0]);
				errs++;
			end
			assert (s.pixel < 0 || dut_pix[i] == PIXEL_W'(s.pixel)) else begin
				$display("** Error at %0t ns: pixel %0d = %0d, expected %0d", $time, i,
					dut_pix[i], s.pixel);
				errs++;
			end
		end
		// block 41 starts the second block row
		if (run == BLOCKS_X && log_address.size() > run * WORDS_PER_BLOCK) begin
			idx = run * WORDS_PER_BLOCK;
			assert (int'(log_address[idx]) == POST_IDCT_BASE + BLOCK_N * POST_ROW_STRIDE)
			else begin
				$display("** Error at %0t ns: sram.address = %0d, expected %0d", $time,
					log_address[idx], POST_IDCT_BASE + BLOCK_N * POST_ROW_STRIDE);
				errs++;
			end
		end
	endtask

	task automatic wait_finish();
		@(posedge CLOCK_50_I);
		while (!finish) begin
			@(posedge CLOCK_50_I);
		end
	endtask

	initial begin
		int errors;
		int failed;
		int run_errors;
		stim_t s;
		errors = 0;
		failed = 0;
		start = 1'b0;
		wait (Resetn);
		for (int run = 0; run < NUM_RUNS; run++) begin
			s = stim_table[run % NUM_ENTRIES];
			blk_row = (run / BLOCKS_X) % BLOCKS_Y;
			blk_col = run % BLOCKS_X;
			load_block(s);
			@(posedge CLOCK_50_I);
			start <= 1'b1;
			@(posedge CLOCK_50_I);
			start <= 1'b0;
			wait_finish();
			model_block();
			check_block(run, s, run_errors);
			errors += run_errors;
			if (run_errors != 0)
				failed++;
			$display("block %0d row %0d col %0d %s: %s", run, blk_row, blk_col, s.mode.name(),
				(run_errors == 0) ? "ok" : "mismatch");
		end
		$display("%0d tests run, %0d failed, %0d errors", NUM_RUNS, failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// just under 600 cycles per block plus one spare block for reset
	initial begin
		repeat ((NUM_RUNS + 1) * BLOCK_CYCLES) @(posedge CLOCK_50_I);
		$display("watchdog: the blocks did not finish within %0d cycles",
			(NUM_RUNS + 1) * BLOCK_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic CLOCK_50_I,
	output logic Resetn
);

	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 4;

	logic clk = 1'b0;

	// 40 ns period
	always #HALF_PERIOD clk = ~clk;

	assign CLOCK_50_I = clk;

	initial begin
		Resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		Resetn <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== idct/coeff_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module coeff_fetch import idct_pkg::*; (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic go_fetch,
	input block_pos_t pos,
	input logic [SAMPLE_W-1:0] sram_read_data,
	output sram_req_t fetch_req,
	output buf_wr_t sp_wr,
	output logic fetch_done
);

	logic issuing;
	logic [5:0] rd_cnt;
	logic [SRAM_ADDR_W-1:0] rd_address;
	logic [SRAM_ADDR_W-1:0] block_base;
	logic [SRAM_READ_LATENCY-1:0] cap_pipe;
	logic capture;
	logic [5:0] cap_cnt;
	logic [SAMPLE_W-1:0] even_coeff;
	logic [BUF_ADDR_W-1:0] wr_address;
	logic [WORD_W-1:0] wr_data;
	logic wr_en;

	assign block_base = SRAM_ADDR_W'(PRE_IDCT_BASE + pos.row * (BLOCK_N * PRE_ROW_STRIDE)
		+ pos.col * BLOCK_N);

	// data for a read shows up SRAM_READ_LATENCY cycles after its address
	assign capture = cap_pipe[SRAM_READ_LATENCY-1];

	assign fetch_req = '{address: rd_address, write_data: '0, write_en_n: 1'b1};
	assign sp_wr = '{address: wr_address, data: wr_data, wren: wr_en};

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			issuing <= 1'b0;
			rd_cnt <= '0;
			cap_pipe <= '0;
			cap_cnt <= '0;
			wr_en <= 1'b0;
			fetch_done <= 1'b0;
		end else begin
			if (go_fetch) begin
				issuing <= 1'b1;
				rd_cnt <= '0;
			end else if (issuing) begin
				rd_cnt <= rd_cnt + 6'd1;
				if (rd_cnt == 6'd63)
					issuing <= 1'b0;
			end
			cap_pipe <= {cap_pipe[SRAM_READ_LATENCY-2:0], issuing};
			// write on every odd coefficient
			wr_en <= capture & cap_cnt[0];
			fetch_done <= capture && (cap_cnt == 6'd63);
			if (capture)
				cap_cnt <= cap_cnt + 6'd1;
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (go_fetch) begin
			rd_address <= block_base;
		end else if (issuing) begin
			// jump to the next image row after eight reads
			if (rd_cnt[2:0] == 3'd7)
				rd_address <= rd_address + SRAM_ADDR_W'(PRE_ROW_STRIDE - BLOCK_N + 1);
			else
				rd_address <= rd_address + SRAM_ADDR_W'(1);
		end
		if (capture) begin
			if (!cap_cnt[0])
				even_coeff <= sram_read_data;
			wr_address <= cap_cnt[5:1];
			wr_data <= {even_coeff, sram_read_data};
		end
	end

endmodule

`default_nettype wire

// ==== idct/pair_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pair_buffer import idct_pkg::*; (
	input logic CLOCK_50_I,
	input buf_wr_t wr,
	input logic [BUF_ADDR_W-1:0] rd_address,
	output logic [WORD_W-1:0] rd_data
);

	logic [WORD_W-1:0] mem [2**BUF_ADDR_W];

	// read-during-write on one address gives the old word
	always_ff @(posedge CLOCK_50_I) begin
		if (wr.wren)
			mem[wr.address] <= wr.data;
		rd_data <= mem[rd_address];
	end

endmodule

`default_nettype wire

// ==== idct/transform_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module transform_engine import idct_pkg::*; (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic go_t,
	input logic go_s,
	output logic [BUF_ADDR_W-1:0] sp_rd_address,
	input logic [WORD_W-1:0] sp_rd_data,
	output logic [BUF_ADDR_W-1:0] t_rd_address,
	input logic [WORD_W-1:0] t_rd_data,
	output buf_wr_t t_wr,
	output logic res_valid,
	output logic signed [WORD_W-1:0] res_value,
	output logic pass_done
);

	// result n: outer index n[5:3], inner index n[2:0], j is the k pair
	logic mode_s;
	logic a_active;
	logic [5:0] a_n;
	logic [1:0] a_j;
	logic b_valid;
	logic [5:0] b_n;
	logic [1:0] b_j;
	logic [WORD_W-1:0] b_word;
	logic signed [SAMPLE_W-1:0] b_even;
	logic signed [SAMPLE_W-1:0] b_odd;
	logic signed [SAMPLE_W-1:0] cos_even;
	logic signed [SAMPLE_W-1:0] cos_odd;
	logic c_valid;
	logic [5:0] c_n;
	logic [1:0] c_j;
	logic signed [WORD_W-1:0] p0;
	logic signed [WORD_W-1:0] p1;
	logic signed [WORD_W-1:0] acc;
	logic res_flag;
	logic res_last;
	logic [5:0] res_n;
	logic signed [SAMPLE_W-1:0] t_val;
	logic signed [SAMPLE_W-1:0] t_even;

	// both passes read word inner*4+j against C[2j][outer] and C[2j+1][outer]
	assign sp_rd_address = {a_n[2:0], a_j};
	assign t_rd_address = {a_n[2:0], a_j};

	assign b_word = mode_s ? t_rd_data : sp_rd_data;
	assign b_even = b_word[WORD_W-1:SAMPLE_W];
	assign b_odd = b_word[SAMPLE_W-1:0];
	assign cos_even = COS_TABLE[{b_j, 1'b0, b_n[5:3]}];
	assign cos_odd = COS_TABLE[{b_j, 1'b1, b_n[5:3]}];

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			mode_s <= 1'b0;
			a_active <= 1'b0;
			a_n <= '0;
			a_j <= '0;
			b_valid <= 1'b0;
			c_valid <= 1'b0;
			res_flag <= 1'b0;
			res_last <= 1'b0;
			pass_done <= 1'b0;
		end else begin
			if (go_t || go_s) begin
				mode_s <= go_s;
				a_active <= 1'b1;
				a_n <= '0;
				a_j <= '0;
			end else if (a_active) begin
				a_j <= a_j + 2'd1;
				if (a_j == 2'd3) begin
					a_n <= a_n + 6'd1;
					if (a_n == 6'd63)
						a_active <= 1'b0;
				end
			end
			b_valid <= a_active;
			c_valid <= b_valid;
			res_flag <= c_valid && (c_j == 2'd3);
			res_last <= c_valid && (c_j == 2'd3) && (c_n == 6'd63);
			pass_done <= res_last;
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		b_n <= a_n;
		b_j <= a_j;
		c_n <= b_n;
		c_j <= b_j;
		p0 <= WORD_W'(b_even) * WORD_W'(cos_even);
		p1 <= WORD_W'(b_odd) * WORD_W'(cos_odd);
		// restart the sum on the first pair of each result
		acc <= ((c_j == 2'd0) ? '0 : acc) + p0 + p1;
		res_n <= c_n;
		if (res_flag && !res_n[0])
			t_even <= t_val;
	end

	assign t_val = SAMPLE_W'(acc >>> T_SHIFT);

	// T[2j][c], T[2j+1][c] land in word c*4+j
	assign t_wr = '{
		address: {res_n[5:3], res_n[2:1]},
		data: {t_even, t_val},
		wren: res_flag & ~mode_s & res_n[0]
	};

	assign res_valid = res_flag & mode_s;
	assign res_value = acc;

endmodule

`default_nettype wire

// ==== project.f ====
common/idct_pkg.sv
idct/coeff_fetch.sv
idct/pair_buffer.sv
idct/transform_engine.sv
source/pixel_writer.sv
source/idct_control.sv
source/idct_top.sv
dv/tb_clock.sv
dv/idct_props.sv
dv/idct_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module idct_tb -Mdir obj_dir -f project.f
./obj_dir/Vidct_tb | tee sim.log

if grep -q "PASS: all tests" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// ==== source/idct_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module idct_control import idct_pkg::*; (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic start,
	input logic fetch_done,
	input logic pass_done,
	input sram_req_t fetch_req,
	input sram_req_t write_req,
	output logic go_fetch,
	output logic go_t,
	output logic go_s,
	output block_pos_t pos,
	output sram_req_t sram,
	output logic finish
);

	phase_t phase;

	// fetcher owns the bus only while fetching
	assign sram = (phase == fetch) ? fetch_req : write_req;

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			phase <= idle;
			go_fetch <= 1'b0;
			go_t <= 1'b0;
			go_s <= 1'b0;
			finish <= 1'b0;
			pos <= '0;
		end else begin
			go_fetch <= 1'b0;
			go_t <= 1'b0;
			go_s <= 1'b0;
			finish <= 1'b0;
			case (phase)
				idle: begin
					if (start) begin
						phase <= fetch;
						go_fetch <= 1'b1;
					end
				end
				fetch: begin
					if (fetch_done) begin
						phase <= pass_t;
						go_t <= 1'b1;
					end
				end
				pass_t: begin
					if (pass_done) begin
						phase <= pass_s;
						go_s <= 1'b1;
					end
				end
				pass_s: begin
					if (pass_done)
						phase <= done;
				end
				done: begin
					finish <= 1'b1;
					phase <= idle;
					// raster step, wraps after the last block
					if (pos.col == 6'(BLOCKS_X - 1)) begin
						pos.col <= '0;
						if (pos.row == 5'(BLOCKS_Y - 1))
							pos.row <= '0;
						else
							pos.row <= pos.row + 5'd1;
					end else begin
						pos.col <= pos.col + 6'd1;
					end
				end
				default: phase <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/idct_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module idct_top import idct_pkg::*; (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic start,
	input logic [SAMPLE_W-1:0] sram_read_data,
	output sram_req_t sram,
	output logic finish
);

	logic go_fetch;
	logic go_t;
	logic go_s;
	logic fetch_done;
	logic pass_done;
	block_pos_t pos;
	sram_req_t fetch_req;
	sram_req_t write_req;
	buf_wr_t sp_wr;
	buf_wr_t t_wr;
	logic [BUF_ADDR_W-1:0] sp_rd_address;
	logic [BUF_ADDR_W-1:0] t_rd_address;
	logic [WORD_W-1:0] sp_rd_data;
	logic [WORD_W-1:0] t_rd_data;
	logic res_valid;
	logic signed [WORD_W-1:0] res_value;

	idct_control i_control (.*);

	coeff_fetch i_fetch (.*);

	// S' coefficients, row pairs
	pair_buffer i_sprime_buf (
		.CLOCK_50_I(CLOCK_50_I),
		.wr(sp_wr),
		.rd_address(sp_rd_address),
		.rd_data(sp_rd_data)
	);

	// intermediate T, column pairs
	pair_buffer i_t_buf (
		.CLOCK_50_I(CLOCK_50_I),
		.wr(t_wr),
		.rd_address(t_rd_address),
		.rd_data(t_rd_data)
	);

	transform_engine i_engine (.*);

	pixel_writer i_writer (.*);

endmodule

`default_nettype wire

// ==== source/pixel_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_writer import idct_pkg::*; (
	input logic CLOCK_50_I,
	input logic Resetn,
	input block_pos_t pos,
	input logic res_valid,
	input logic signed [WORD_W-1:0] res_value,
	output sram_req_t write_req
);

	logic [5:0] res_cnt;
	logic [PIXEL_W-1:0] pixel;
	logic [PIXEL_W-1:0] even_pixel;
	logic [SRAM_ADDR_W-1:0] block_base;
	logic wr_en_n;
	logic [SRAM_ADDR_W-1:0] wr_address;
	logic [SAMPLE_W-1:0] wr_data;

	function automatic logic [PIXEL_W-1:0] clip_pixel(input logic signed [WORD_W-1:0] sum);
		logic signed [WORD_W-1:0] scaled;
		scaled = sum >>> S_SHIFT;
		if (scaled < 0)
			return '0;
		else if (scaled > (2**PIXEL_W - 1))
			return '1;
		else
			return scaled[PIXEL_W-1:0];
	endfunction

	assign pixel = clip_pixel(res_value);
	assign block_base = SRAM_ADDR_W'(POST_IDCT_BASE + pos.row * (BLOCK_N * POST_ROW_STRIDE)
		+ pos.col * (BLOCK_N / 2));

	assign write_req = '{address: wr_address, write_data: wr_data, write_en_n: wr_en_n};

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			res_cnt <= '0;
			wr_en_n <= 1'b1;
		end else begin
			if (res_valid)
				res_cnt <= res_cnt + 6'd1;
			// one write per pixel pair, on the odd column
			wr_en_n <= ~(res_valid & res_cnt[0]);
		end
	end

	// res_cnt holds row r in [5:3] and pair index m in [2:1]
	always_ff @(posedge CLOCK_50_I) begin
		if (res_valid) begin
			if (!res_cnt[0])
				even_pixel <= pixel;
			wr_data <= {even_pixel, pixel};
			wr_address <= block_base + SRAM_ADDR_W'(res_cnt[5:3] * POST_ROW_STRIDE)
				+ SRAM_ADDR_W'(res_cnt[2:1]);
		end
	end

endmodule

`default_nettype wire
